// ==== build.f ====
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_id_ex_reg.sv
src/rv_execute.sv
src/rv_pipe_ctrl.sv
src/rv_id_ex_core.sv
verif/rv_id_ex_properties.sv
verif/tb_rv_id_ex_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rv_id_ex_core -Mdir obj_dir -f build.f
out=$(./obj_dir/Vtb_rv_id_ex_core 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// ==== src/rv_decoder.sv ====
module rv_decoder (
    input  rv_pkg::instr_t    instr_i,
    input  rv_pkg::pc_t       pc_i,
    input  logic              valid_i,
    output rv_pkg::reg_addr_t rs1_addr_o,
    output rv_pkg::reg_addr_t rs2_addr_o,
    input  rv_pkg::xlen_t     rs1_data_i,
    input  rv_pkg::xlen_t     rs2_data_i,
    output rv_pkg::id_ex_t    bundle_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    logic          wr_en;
    rv_pkg::xlen_t imm_i, imm_u, imm_b, imm_j;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign imm_i = {{52{instr_i[31]}}, instr_i[31:20]};
    assign imm_u = {{32{instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_b = {{51{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{43{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? rv_pkg::SUB : rv_pkg::ADD;
            3'b001:  alu_sel = rv_pkg::SLL;
            3'b010:  alu_sel = rv_pkg::SLT;
            3'b011:  alu_sel = rv_pkg::SLTU;
            3'b100:  alu_sel = rv_pkg::XOR;
            3'b101:  alu_sel = alt ? rv_pkg::SRA : rv_pkg::SRL;
            3'b110:  alu_sel = rv_pkg::OR;
            default: alu_sel = rv_pkg::AND;
        endcase
    endfunction

    always_comb begin
        bundle_o          = '0;
        bundle_o.valid    = valid_i;
        bundle_o.rd       = instr_i[11:7];
        bundle_o.rs1_data = rs1_data_i;
        bundle_o.rs2_data = rs2_data_i;
        bundle_o.pc       = pc_i;
        wr_en             = 1'b0;
        case (opcode)
            OPC_OP: begin
                // sub and sra are the only alternate encodings
                if (funct7 == 7'b0000000 ||
                    (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101))) begin
                    wr_en           = 1'b1;
                    bundle_o.alu_op = alu_sel(funct3, funct7[5]);
                end
            end
            OPC_OP_IMM: begin
                // rv64 shifts carry a 6-bit shamt below funct6
                if (funct3 == 3'b001) begin
                    wr_en = (instr_i[31:26] == 6'b000000);
                end else if (funct3 == 3'b101) begin
                    wr_en = (instr_i[31:26] == 6'b000000) || (instr_i[31:26] == 6'b010000);
                end else begin
                    wr_en = 1'b1;
                end
                bundle_o.alu_op = alu_sel(funct3, funct3 == 3'b101 && instr_i[30]);
                bundle_o.sel_b  = rv_pkg::IMM;
                bundle_o.imm    = imm_i;
            end
            OPC_LUI: begin
                wr_en           = 1'b1;
                bundle_o.alu_op = rv_pkg::PASS_B;
                bundle_o.sel_b  = rv_pkg::IMM;
                bundle_o.imm    = imm_u;
            end
            OPC_AUIPC: begin
                wr_en          = 1'b1;
                bundle_o.sel_a = rv_pkg::PC;
                bundle_o.sel_b = rv_pkg::IMM;
                bundle_o.imm   = imm_u;
            end
            OPC_JAL: begin
                wr_en        = 1'b1;
                bundle_o.jal = 1'b1;
                bundle_o.imm = imm_j;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    wr_en         = 1'b1;
                    bundle_o.jalr = 1'b1;
                    bundle_o.imm  = imm_i;
                end
            end
            OPC_BRANCH: begin
                bundle_o.imm = imm_b;
                case (funct3)
                    3'b000:  bundle_o.br_op = rv_pkg::EQ;
                    3'b001:  bundle_o.br_op = rv_pkg::NE;
                    3'b100:  bundle_o.br_op = rv_pkg::LT;
                    3'b101:  bundle_o.br_op = rv_pkg::GE;
                    3'b110:  bundle_o.br_op = rv_pkg::LTU;
                    3'b111:  bundle_o.br_op = rv_pkg::GEU;
                    default: bundle_o.br_op = rv_pkg::NONE;   // no-op
                endcase
            end
            default: ;   // unsupported encodings decode as no-op
        endcase
        bundle_o.write_rd = wr_en && (instr_i[11:7] != 5'd0);
    end

endmodule

// ==== src/rv_execute.sv ====
module rv_execute (
    input  rv_pkg::id_ex_t    bundle_i,
    input  logic              hold_i,
    output logic              wb_valid_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::xlen_t     wb_data_o,
    output logic              redirect_o,
    output rv_pkg::pc_t       redirect_pc_o
);

    rv_pkg::xlen_t op_a;
    rv_pkg::xlen_t op_b;
    rv_pkg::xlen_t alu_res;
    logic [5:0]    shamt;
    logic          fire;
    logic          br_eq;
    logic          br_lt;
    logic          br_ltu;
    logic          br_taken;
    rv_pkg::pc_t   link_pc;

    assign op_a  = (bundle_i.sel_a == rv_pkg::PC) ? bundle_i.pc : bundle_i.rs1_data;
    assign op_b  = (bundle_i.sel_b == rv_pkg::IMM) ? bundle_i.imm : bundle_i.rs2_data;
    assign shamt = op_b[5:0];

    always_comb begin
        case (bundle_i.alu_op)
            rv_pkg::ADD:    alu_res = op_a + op_b;
            rv_pkg::SUB:    alu_res = op_a - op_b;
            rv_pkg::SLL:    alu_res = op_a << shamt;
            rv_pkg::SLT:    alu_res = {63'b0, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU:   alu_res = {63'b0, op_a < op_b};
            rv_pkg::XOR:    alu_res = op_a ^ op_b;
            rv_pkg::SRL:    alu_res = op_a >> shamt;
            rv_pkg::SRA:    alu_res = $signed(op_a) >>> shamt;
            rv_pkg::OR:     alu_res = op_a | op_b;
            rv_pkg::AND:    alu_res = op_a & op_b;
            rv_pkg::PASS_B: alu_res = op_b;
            default:        alu_res = '0;
        endcase
    end

    // branches always compare the two registers
    assign br_eq  = (bundle_i.rs1_data == bundle_i.rs2_data);
    assign br_lt  = ($signed(bundle_i.rs1_data) < $signed(bundle_i.rs2_data));
    assign br_ltu = (bundle_i.rs1_data < bundle_i.rs2_data);

    always_comb begin
        case (bundle_i.br_op)
            rv_pkg::EQ:  br_taken = br_eq;
            rv_pkg::NE:  br_taken = !br_eq;
            rv_pkg::LT:  br_taken = br_lt;
            rv_pkg::GE:  br_taken = !br_lt;
            rv_pkg::LTU: br_taken = br_ltu;
            rv_pkg::GEU: br_taken = !br_ltu;
            default:     br_taken = 1'b0;
        endcase
    end

    assign fire    = bundle_i.valid && !hold_i;
    assign link_pc = bundle_i.pc + 64'd4;

    assign wb_valid_o = fire && bundle_i.write_rd;
    assign wb_rd_o    = bundle_i.rd;
    assign wb_data_o  = (bundle_i.jal || bundle_i.jalr) ? link_pc : alu_res;

    assign redirect_o    = fire && (bundle_i.jal || bundle_i.jalr || br_taken);
    assign redirect_pc_o = bundle_i.jalr
                         ? ((bundle_i.rs1_data + bundle_i.imm) & ~64'd1)   // lsb cleared
                         : (bundle_i.pc + bundle_i.imm);

endmodule

// ==== src/rv_id_ex_core.sv ====
module rv_id_ex_core (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  logic              instr_valid_i,
    input  rv_pkg::instr_t    instr_i,
    input  rv_pkg::pc_t       pc_i,
    input  logic              hold_i,
    output logic              fetch_stall_o,
    output logic              wb_valid_o,
    output rv_pkg::reg_addr_t wb_rd_o,
    output rv_pkg::xlen_t     wb_data_o,
    output logic              redirect_o,
    output rv_pkg::pc_t       redirect_pc_o
);

    rv_pkg::id_ex_t    id_bundle;
    rv_pkg::id_ex_t    ex_bundle;
    rv_pkg::reg_addr_t rs1_addr;
    rv_pkg::reg_addr_t rs2_addr;
    rv_pkg::xlen_t     rs1_data;
    rv_pkg::xlen_t     rs2_data;
    logic              id_flush;
    logic              id_hold;

    rv_decoder u_decoder (
        .instr_i    (instr_i),
        .pc_i       (pc_i),
        .valid_i    (instr_valid_i),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .bundle_o   (id_bundle)
    );

    rv_regfile u_regfile (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (wb_valid_o),   // writeback from execute
        .wr_addr_i  (wb_rd_o),
        .wr_data_i  (wb_data_o)
    );

    rv_id_ex_reg u_id_ex_reg (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flush_i  (id_flush),
        .hold_i   (id_hold),
        .bundle_i (id_bundle),
        .bundle_o (ex_bundle)
    );

    rv_execute u_execute (
        .bundle_i      (ex_bundle),
        .hold_i        (hold_i),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .redirect_o    (redirect_o),
        .redirect_pc_o (redirect_pc_o)
    );

    rv_pipe_ctrl u_pipe_ctrl (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .hold_i        (hold_i),
        .redirect_i    (redirect_o),
        .id_flush_o    (id_flush),
        .id_hold_o     (id_hold),
        .fetch_stall_o (fetch_stall_o)
    );

endmodule

// ==== src/rv_id_ex_reg.sv ====
module rv_id_ex_reg (
    input  logic           clk_i,
    input  logic           arst_n_i,
    input  logic           flush_i,
    input  logic           hold_i,
    input  rv_pkg::id_ex_t bundle_i,
    output rv_pkg::id_ex_t bundle_o
);

    // clear beats hold, hold beats load
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bundle_o <= '0;
        end else if (flush_i) begin
            bundle_o <= '0;        // bubble
        end else if (!hold_i) begin
            bundle_o <= bundle_i;
        end
    end

endmodule

// ==== src/rv_pipe_ctrl.sv ====
module rv_pipe_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic instr_valid_i,
    input  logic hold_i,
    input  logic redirect_i,
    output logic id_flush_o,
    output logic id_hold_o,
    output logic fetch_stall_o
);

    rv_pkg::ctrl_state_e state_q;
    rv_pkg::ctrl_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            rv_pkg::RUN: begin
                if (redirect_i) begin
                    state_d = rv_pkg::SQUASH;
                end
            end
            rv_pkg::SQUASH: begin
                if (!hold_i) begin
                    state_d = rv_pkg::RUN;   // one unheld slot dropped
                end
            end
            default: state_d = rv_pkg::RUN;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= rv_pkg::RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Drop the redirect-cycle slot and the slot after it. An empty input
    // cycle also loads a bubble so the last instruction does not repeat.
    assign id_flush_o = !hold_i &&
                        (redirect_i || state_q == rv_pkg::SQUASH || !instr_valid_i);

    assign id_hold_o     = hold_i;
    assign fetch_stall_o = hold_i;

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;     // data word
    typedef logic [XLEN-1:0] pc_t;       // instruction address
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_addr_t;

    // ADD must stay at zero so an all-zero bundle is a bubble
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10   // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        NONE = 3'd0,
        EQ   = 3'd1,
        NE   = 3'd2,
        LT   = 3'd3,
        GE   = 3'd4,
        LTU  = 3'd5,
        GEU  = 3'd6
    } br_op_e;

    typedef enum logic {
        RS1 = 1'b0,
        PC  = 1'b1
    } sel_a_e;

    typedef enum logic {
        RS2 = 1'b0,
        IMM = 1'b1
    } sel_b_e;

    typedef enum logic {
        RUN    = 1'b0,
        SQUASH = 1'b1    // wrong-path slot after a redirect
    } ctrl_state_e;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        sel_a_e    sel_a;
        sel_b_e    sel_b;
        br_op_e    br_op;
        logic      jal;
        logic      jalr;
        logic      write_rd;   // low for rd == x0
        reg_addr_t rd;
        xlen_t     rs1_data;
        xlen_t     rs2_data;
        xlen_t     imm;
        pc_t       pc;
    } id_ex_t;

endpackage

// ==== src/rv_regfile.sv ====
module rv_regfile (
    input  logic              clk_i,
    input  logic              arst_n_i,
    input  rv_pkg::reg_addr_t rs1_addr_i,
    input  rv_pkg::reg_addr_t rs2_addr_i,
    output rv_pkg::xlen_t     rs1_data_o,
    output rv_pkg::xlen_t     rs2_data_o,
    input  logic              we_i,
    input  rv_pkg::reg_addr_t wr_addr_i,
    input  rv_pkg::xlen_t     wr_data_i
);

    rv_pkg::xlen_t regs [1:31];   // no storage for x0

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wr_addr_i != 5'd0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    function automatic rv_pkg::xlen_t rd_port(input rv_pkg::reg_addr_t addr);
        if (addr == 5'd0) begin
            rd_port = '0;
        end else if (we_i && wr_addr_i == addr) begin
            rd_port = wr_data_i;   // write-through
        end else begin
            rd_port = regs[addr];
        end
    endfunction

    assign rs1_data_o = rd_port(rs1_addr_i);
    assign rs2_data_o = rd_port(rs2_addr_i);

endmodule

// ==== verif/rv_id_ex_properties.sv ====
module rv_id_ex_properties (
    input logic clk_i,
    input logic arst_n_i,
    input logic hold_i,
    input logic fetch_stall_i,
    input logic wb_valid_i,
    input logic redirect_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // sampled mid-cycle, where all levels are settled
    hold_blocks_execute: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        hold_i |-> (!wb_valid_i && !redirect_i))
        else $error("writeback or redirect while hold_i is high");

    stall_follows_hold: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        fetch_stall_i == hold_i)
        else $error("fetch_stall_o differs from hold_i");

    // two wrong-path slots after a taken transfer
    squash_after_redirect: assert property (@(negedge clk_i) disable iff (!arst_n_i)
        ($past(redirect_i && !hold_i) || $past(redirect_i && !hold_i, 2)) |-> !wb_valid_i)
        else $error("writeback from a wrong-path slot after a redirect");

endmodule

// ==== verif/tb_rv_id_ex_core.sv ====
module tb_rv_id_ex_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD  = 10;
    localparam int N_INSTR = 500;

    typedef struct packed {
        logic              wb;
        rv_pkg::reg_addr_t rd;
        rv_pkg::xlen_t     data;
        logic              redir;
        rv_pkg::pc_t       target;
    } exp_t;

    logic              clk_i;
    logic              arst_n_i;
    logic              instr_valid_i;
    rv_pkg::instr_t    instr_i;
    rv_pkg::pc_t       pc_i;
    logic              hold_i;
    logic              fetch_stall_o;
    logic              wb_valid_o;
    rv_pkg::reg_addr_t wb_rd_o;
    rv_pkg::xlen_t     wb_data_o;
    logic              redirect_o;
    rv_pkg::pc_t       redirect_pc_o;

    int            seed = 64;
    int            accepted = 0;
    rv_pkg::xlen_t shadow [32];              // architectural registers
    exp_t          exp_q [$];
    exp_t          ex_item = '0;             // what sits in ID/EX
    logic          ex_busy = 1'b0;
    logic          squash = 1'b0;
    rv_pkg::pc_t   next_pc = 64'h8000_0000;

    rv_id_ex_core u_dut (.*);

    bind rv_id_ex_core rv_id_ex_properties u_props (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .hold_i        (hold_i),
        .fetch_stall_i (fetch_stall_o),
        .wb_valid_i    (wb_valid_o),
        .redirect_i    (redirect_o)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic pick_instr(output rv_pkg::instr_t ins);
        logic [31:0] r1;
        logic [31:0] r2;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        r1  = $random(seed);
        r2  = $random(seed);
        rd  = {2'b00, r1[2:0]};   // x0..x7 keeps dependencies dense
        rs1 = {2'b00, r1[5:3]};
        rs2 = {2'b00, r1[8:6]};
        f3  = r2[14:12];
        case (r1[12:9])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
                ins = {1'b0, r2[3] && (f3 == 3'd0 || f3 == 3'd5), 5'b00000,
                       rs2, rs1, f3, rd, 7'b0110011};
            end
            4'd5, 4'd6, 4'd7, 4'd8: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    r2[31:26] = {1'b0, r2[30] && f3 == 3'd5, 4'b0000};   // shift funct6
                end
                ins = {r2[31:20], rs1, f3, rd, 7'b0010011};
            end
            4'd9:    ins = {r2[31:12], rd, 7'b0110111};
            4'd10:   ins = {r2[31:12], rd, 7'b0010111};
            4'd11:   ins = {r2[31:12], rd, 7'b1101111};
            4'd12:   ins = {r2[31:20], rs1, 3'b000, rd, 7'b1100111};
            default: begin
                if (f3[2:1] == 2'b01) begin
                    f3[2:1] = 2'b10;   // funct3 2 and 3 are not branches
                end
                ins = {r2[31:25], rs2, rs1, f3, r2[11:7], 7'b1100011};
            end
        endcase
    endtask

    function automatic exp_t ref_exec(input rv_pkg::instr_t ins, input rv_pkg::pc_t pc,
                                      input rv_pkg::xlen_t a, input rv_pkg::xlen_t b);
        exp_t          e;
        rv_pkg::xlen_t imm_i;
        rv_pkg::xlen_t imm_u;
        rv_pkg::xlen_t imm_b;
        rv_pkg::xlen_t imm_j;
        rv_pkg::xlen_t op_b;
        rv_pkg::xlen_t res;
        logic          r_type;
        logic          lt;
        e      = '0;
        e.rd   = ins[11:7];
        r_type = (ins[6:0] == 7'b0110011);
        imm_i  = 64'(signed'(ins[31:20]));
        imm_u  = 64'(signed'({ins[31:12], 12'h000}));
        imm_b  = 64'(signed'({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}));
        imm_j  = 64'(signed'({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}));
        op_b   = r_type ? b : imm_i;
        case (ins[14:12])
            3'd0: res = (r_type && ins[30]) ? a - op_b : a + op_b;
            3'd1: res = a << op_b[5:0];
            3'd2: res = {63'd0, (a[63] != op_b[63]) ? a[63] : (a < op_b)};
            3'd3: res = {63'd0, a < op_b};
            3'd4: res = a ^ op_b;
            3'd5: res = (a >> op_b[5:0]) | ({64{a[63] & ins[30]}} & ~({64{1'b1}} >> op_b[5:0]));
            3'd6: res = a | op_b;
            default: res = a & op_b;
        endcase
        lt = (a[63] != b[63]) ? a[63] : (a < b);
        case (ins[6:0])
            7'b0110011, 7'b0010011: e.data = res;
            7'b0110111: e.data = imm_u;
            7'b0010111: e.data = pc + imm_u;
            7'b1101111, 7'b1100111: begin
                e.data   = pc + 64'd4;   // link address
                e.redir  = 1'b1;
                e.target = ins[3] ? pc + imm_j : (a + imm_i) & ~64'd1;
            end
            default: begin
                case (ins[14:12])
                    3'd0:    e.redir = (a == b);
                    3'd1:    e.redir = (a != b);
                    3'd4:    e.redir = lt;
                    3'd5:    e.redir = !lt;
                    3'd6:    e.redir = (a < b);
                    default: e.redir = (a >= b);
                endcase
                e.target = pc + imm_b;
            end
        endcase
        e.wb = (ins[6:0] != 7'b1100011) && (e.rd != 5'd0);
        return e;
    endfunction

    initial begin
        clk_i = 1'b0;
        forever #(PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #((4 * N_INSTR + 100) * PERIOD);
        abort_run("watchdog expired before all instructions completed");
    end

    initial begin
        rv_pkg::instr_t ins;
        exp_t           e;
        logic [31:0]    r;
        logic           taken;
        rv_pkg::pc_t    tgt;
        arst_n_i      <= 1'b0;
        instr_valid_i <= 1'b0;
        instr_i       <= '0;
        pc_i          <= '0;
        hold_i        <= 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (16) @(posedge clk_i);
        arst_n_i <= 1'b1;
        forever begin
            @(posedge clk_i);
            // settle the cycle that just ended
            if (!hold_i) begin
                taken = ex_busy && ex_item.redir;
                tgt   = ex_item.target;
                if (instr_valid_i && !taken && !squash) begin
                    e = ref_exec(instr_i, pc_i, shadow[instr_i[19:15]], shadow[instr_i[24:20]]);
                    if (e.wb) begin
                        shadow[e.rd] = e.data;
                    end
                    if (e.wb || e.redir) begin
                        exp_q.push_back(e);
                    end
                    ex_item = e;
                    ex_busy = 1'b1;
                    accepted++;
                end else begin
                    ex_busy = 1'b0;   // bubble loaded
                end
                squash = taken;
                if (taken) begin
                    next_pc = tgt;
                end
            end
            if (accepted == N_INSTR) break;
            r = $random(seed);
            if (!hold_i) begin
                pick_instr(ins);
                instr_i       <= ins;
                pc_i          <= next_pc;
                instr_valid_i <= (r[4:2] != 3'd0);
                next_pc = next_pc + 64'd4;
            end
            hold_i <= (r[1:0] == 2'd0);
        end
        instr_valid_i <= 1'b0;
        hold_i        <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        $display("TEST OK");
        $finish;
    end

    always @(negedge clk_i) begin
        exp_t e;
        if (arst_n_i) begin
            check("fetch_stall_o", 64'(fetch_stall_o), 64'(hold_i));
            if (wb_valid_o || redirect_o) begin
                if (hold_i) begin
                    abort_run("writeback or redirect while hold_i is high");
                end
                if (exp_q.size() == 0) begin
                    abort_run("writeback or redirect with no accepted instruction pending");
                end
                e = exp_q.pop_front();
                check("wb_valid_o", 64'(wb_valid_o), 64'(e.wb));
                check("redirect_o", 64'(redirect_o), 64'(e.redir));
                if (e.wb) begin
                    check("wb_rd_o", 64'(wb_rd_o), 64'(e.rd));
                    check("wb_data_o", wb_data_o, e.data);
                end
                if (e.redir) begin
                    check("redirect_pc_o", redirect_pc_o, e.target);
                end
            end
        end
    end

endmodule
